//--- xgmii_rx_config.svh
// xgmii receiver constants
`ifndef XGMII_RX_CONFIG_SVH
`define XGMII_RX_CONFIG_SVH

// bus widths
`define XGMII_DATA_W 64
`define XGMII_CTRL_W 8

// xgmii control characters
`define XGMII_START 8'hfb
`define XGMII_TERM 8'hfd

// ethernet preamble and start frame delimiter
`define ETH_PRE 8'h55
`define ETH_SFD 8'hd5

// crc-32 generator polynomial, normal form
`define ETH_CRC_POLY 32'h04c11db7

`endif

//--- xgmii_rx_pkg.sv
// xgmii receiver types
`include "xgmii_rx_config.svh"

package xgmii_rx_pkg;

    // one xgmii word and its control flags
    typedef logic [`XGMII_DATA_W-1:0] xgmii_data_t;
    typedef logic [`XGMII_CTRL_W-1:0] xgmii_ctrl_t;

    // byte lane number within a word
    typedef logic [2:0] lane_idx_t;

    // frame length in bytes, fcs included
    typedef logic [15:0] pkt_len_t;

    // frame receive states
    typedef enum logic [1:0] {
        rx_idle    = 2'd0,
        rx_payload = 2'd1,
        rx_last    = 2'd2
    } rx_state_e;

endpackage

//--- xgmii_lane_decode.sv
// xgmii lane decoder
`timescale 1ns/1ps
`include "xgmii_rx_config.svh"

module xgmii_lane_decode (
    input  logic                      clk,
    input  logic                      reset_crc,
    input  xgmii_rx_pkg::xgmii_data_t xgmii_rxd,
    input  xgmii_rx_pkg::xgmii_ctrl_t xgmii_rxc,
    output xgmii_rx_pkg::xgmii_data_t rxd_d0,
    output xgmii_rx_pkg::xgmii_data_t rxd_d1,
    output logic                      start_d1,
    output logic                      term_present,
    output logic                      term_first_cycle,
    output logic                      framing_error,
    output logic                      framing_error_d0,
    output xgmii_rx_pkg::lane_idx_t   term_lane,
    output xgmii_rx_pkg::lane_idx_t   term_lane_d0
);

    xgmii_rx_pkg::xgmii_data_t rxd_masked;
    xgmii_rx_pkg::xgmii_ctrl_t term_hit;
    xgmii_rx_pkg::xgmii_ctrl_t below_term;
    xgmii_rx_pkg::lane_idx_t   term_idx;
    logic                      term_any;
    logic                      start_hit;
    logic                      ctrl_err;
    logic                      start_d0;

    // zero control bytes above lane 0 and flag terminate characters
    always_comb begin
        for (int n = 0; n < `XGMII_CTRL_W; n++) begin
            if (n > 0 && xgmii_rxc[n]) begin
                rxd_masked[n*8 +: 8] = 8'd0;
            end else begin
                rxd_masked[n*8 +: 8] = xgmii_rxd[n*8 +: 8];
            end
            term_hit[n] = xgmii_rxc[n] && (xgmii_rxd[n*8 +: 8] == `XGMII_TERM);
        end
    end

    // lowest terminate lane wins
    always_comb begin
        term_any = 1'b0;
        term_idx = '0;
        for (int i = `XGMII_CTRL_W-1; i >= 0; i--) begin
            if (term_hit[i]) begin
                term_any = 1'b1;
                term_idx = 3'(i);
            end
        end
    end

    assign start_hit = xgmii_rxc[0] && (xgmii_rxd[7:0] == `XGMII_START);
    assign below_term = ~({`XGMII_CTRL_W{1'b1}} << term_idx);

    // any control byte ahead of the terminate is a framing error
    always_comb begin
        if (term_any) begin
            ctrl_err = |(xgmii_rxc & below_term);
        end else begin
            ctrl_err = |xgmii_rxc;
        end
    end

    always_ff @(posedge clk) begin
        rxd_d0 <= rxd_masked;
        rxd_d1 <= rxd_d0;
        term_lane <= term_idx;
        term_lane_d0 <= term_lane;
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            start_d0 <= 1'b0;
            start_d1 <= 1'b0;
            term_present <= 1'b0;
            term_first_cycle <= 1'b0;
            framing_error <= 1'b0;
            framing_error_d0 <= 1'b0;
        end else begin
            start_d0 <= start_hit;
            start_d1 <= start_d0;
            term_present <= term_any;
            // fcs complete within this word when terminate sits in lanes 0 to 4
            term_first_cycle <= term_any && (term_idx <= 3'd4);
            framing_error <= ctrl_err;
            framing_error_d0 <= framing_error;
        end
    end

endmodule

//--- eth_crc32_64.sv
// ethernet crc-32, 64 bits per cycle
`timescale 1ns/1ps
`include "xgmii_rx_config.svh"

module eth_crc32_64 (
    input  logic                      clk,
    input  logic                      reset_crc,
    input  logic                      crc_clear,
    input  xgmii_rx_pkg::xgmii_data_t rxd_d0,
    output logic [7:0]                crc_match,
    output logic [7:0]                crc_match_save
);

    function automatic logic [31:0] reflect32(input logic [31:0] v);
        logic [31:0] r;
        for (int i = 0; i < 32; i++) begin
            r[i] = v[31-i];
        end
        return r;
    endfunction

    localparam logic [31:0] poly_refl = reflect32(`ETH_CRC_POLY);

    // state after a frame whose fcs ends in lane n, trailing lanes zeroed
    localparam logic [7:0][31:0] crc_residue = {
        32'h2144df1c,
        32'hc622f71d,
        32'hb1c2a1a3,
        32'h9d6cdf7e,
        32'h6522df69,
        32'he60914ae,
        32'he38a6876,
        32'h6b87b1ec
    };

    // lsb first, one bit per step
    function automatic logic [31:0] crc_advance(
        input logic [31:0]               crc,
        input xgmii_rx_pkg::xgmii_data_t d
    );
        logic [31:0] c;
        c = crc;
        for (int i = 0; i < `XGMII_DATA_W; i++) begin
            if (c[0] ^ d[i]) begin
                c = (c >> 1) ^ poly_refl;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    logic [31:0] crc_state;
    logic [31:0] crc_next;

    assign crc_next = crc_advance(crc_state, rxd_d0);

    always_comb begin
        for (int j = 0; j < `XGMII_CTRL_W; j++) begin
            crc_match[j] = (crc_next == ~crc_residue[j]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc || crc_clear) begin
            crc_state <= '1;
        end else begin
            crc_state <= crc_next;
        end
    end

    // previous word's matches, for early-lane and spill-over terminates
    always_ff @(posedge clk) begin
        if (reset_crc) begin
            crc_match_save <= '0;
        end else begin
            crc_match_save <= crc_match;
        end
    end

endmodule

//--- xgmii_rx_fsm.sv
// xgmii receive frame fsm
`timescale 1ns/1ps
`include "xgmii_rx_config.svh"

module xgmii_rx_fsm (
    input  logic                      clk,
    input  logic                      reset_crc,
    input  logic                      cfg_rx_enable,
    input  logic                      start_d1,
    input  logic                      term_present,
    input  logic                      term_first_cycle,
    input  logic                      framing_error,
    input  logic                      framing_error_d0,
    input  xgmii_rx_pkg::xgmii_data_t rxd_d1,
    input  xgmii_rx_pkg::lane_idx_t   term_lane,
    input  xgmii_rx_pkg::lane_idx_t   term_lane_d0,
    input  logic [7:0]                crc_match,
    input  logic [7:0]                crc_match_save,
    output logic                      crc_clear,
    output xgmii_rx_pkg::xgmii_data_t m_axis_tdata,
    output xgmii_rx_pkg::xgmii_ctrl_t m_axis_tkeep,
    output logic                      m_axis_tvalid,
    output logic                      m_axis_tlast,
    output logic                      m_axis_tuser,
    output logic                      stat_rx_pkt_good,
    output logic                      stat_rx_pkt_bad,
    output logic                      stat_rx_err_bad_fcs,
    output logic                      stat_rx_err_framing,
    output logic                      stat_rx_err_preamble,
    output xgmii_rx_pkg::pkt_len_t    stat_rx_pkt_len
);

    localparam logic [55:0] pre_sfd = {`ETH_SFD, {6{`ETH_PRE}}};
    localparam xgmii_rx_pkg::xgmii_ctrl_t keep_all = {`XGMII_CTRL_W{1'b1}};

    xgmii_rx_pkg::rx_state_e   state, state_next;
    xgmii_rx_pkg::pkt_len_t    frame_len, frame_len_next;
    logic                      pre_ok, pre_ok_next;
    logic                      crc_ok_first, crc_ok_last;
    xgmii_rx_pkg::xgmii_ctrl_t tkeep_next;
    logic                      tvalid_next, tlast_next, tuser_next;
    logic                      good_next, bad_next, fcs_next, framing_next, pre_err_next;
    xgmii_rx_pkg::pkt_len_t    len_next;

    // terminate in lane 0 means the fcs closed the previous word
    assign crc_ok_first = (term_lane == 3'd0) ? crc_match_save[7]
                                              : crc_match[term_lane - 3'd1];
    assign crc_ok_last = crc_match_save[term_lane_d0 - 3'd1];

    always_comb begin
        state_next = xgmii_rx_pkg::rx_idle;
        crc_clear = 1'b0;
        pre_ok_next = pre_ok;
        tkeep_next = keep_all;
        tvalid_next = 1'b0;
        tlast_next = 1'b0;
        tuser_next = 1'b0;
        good_next = 1'b0;
        bad_next = 1'b0;
        fcs_next = 1'b0;
        framing_next = 1'b0;
        pre_err_next = 1'b0;
        len_next = '0;

        // counts the word one stage ahead of the output, saturating
        if (!(&frame_len[15:3])) begin
            if (term_present) begin
                frame_len_next = frame_len + xgmii_rx_pkg::pkt_len_t'(term_lane);
            end else begin
                frame_len_next = frame_len + xgmii_rx_pkg::pkt_len_t'(`XGMII_CTRL_W);
            end
        end else begin
            frame_len_next = '1;
        end

        case (state)
            xgmii_rx_pkg::rx_idle: begin
                crc_clear = 1'b1;
                frame_len_next = xgmii_rx_pkg::pkt_len_t'(`XGMII_CTRL_W);
                pre_ok_next = (rxd_d1[63:8] == pre_sfd);
                if (start_d1 && cfg_rx_enable) begin
                    crc_clear = 1'b0;
                    state_next = xgmii_rx_pkg::rx_payload;
                end
            end
            xgmii_rx_pkg::rx_payload: begin
                tvalid_next = 1'b1;
                if (framing_error || framing_error_d0) begin
                    // cut the frame short
                    tlast_next = 1'b1;
                    tuser_next = 1'b1;
                    bad_next = 1'b1;
                    framing_next = 1'b1;
                    pre_err_next = !pre_ok;
                    len_next = frame_len_next;
                    crc_clear = 1'b1;
                end else if (term_first_cycle) begin
                    // fcs lanes dropped from keep
                    tkeep_next = keep_all >> (3'd4 - term_lane);
                    tlast_next = 1'b1;
                    if (crc_ok_first) begin
                        good_next = 1'b1;
                    end else begin
                        tuser_next = 1'b1;
                        bad_next = 1'b1;
                        fcs_next = 1'b1;
                    end
                    pre_err_next = !pre_ok;
                    len_next = frame_len_next;
                    crc_clear = 1'b1;
                end else if (term_present) begin
                    state_next = xgmii_rx_pkg::rx_last;
                end else begin
                    state_next = xgmii_rx_pkg::rx_payload;
                end
            end
            xgmii_rx_pkg::rx_last: begin
                // terminate in lanes 5 to 7, shift wraps modulo 8
                tvalid_next = 1'b1;
                tlast_next = 1'b1;
                tkeep_next = keep_all >> (3'd4 - term_lane_d0);
                crc_clear = 1'b1;
                if (crc_ok_last) begin
                    good_next = 1'b1;
                end else begin
                    tuser_next = 1'b1;
                    bad_next = 1'b1;
                    fcs_next = 1'b1;
                end
                pre_err_next = !pre_ok;
                len_next = frame_len;
            end
            default: begin
                state_next = xgmii_rx_pkg::rx_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        m_axis_tdata <= rxd_d1;
        m_axis_tkeep <= tkeep_next;
        m_axis_tlast <= tlast_next;
        m_axis_tuser <= tuser_next;
        frame_len <= frame_len_next;
        pre_ok <= pre_ok_next;
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            state <= xgmii_rx_pkg::rx_idle;
            m_axis_tvalid <= 1'b0;
            stat_rx_pkt_good <= 1'b0;
            stat_rx_pkt_bad <= 1'b0;
            stat_rx_err_bad_fcs <= 1'b0;
            stat_rx_err_framing <= 1'b0;
            stat_rx_err_preamble <= 1'b0;
            stat_rx_pkt_len <= '0;
        end else begin
            state <= state_next;
            m_axis_tvalid <= tvalid_next;
            stat_rx_pkt_good <= good_next;
            stat_rx_pkt_bad <= bad_next;
            stat_rx_err_bad_fcs <= fcs_next;
            stat_rx_err_framing <= framing_next;
            stat_rx_err_preamble <= pre_err_next;
            stat_rx_pkt_len <= len_next;
        end
    end

endmodule

//--- xgmii_rx_top.sv
// xgmii frame receiver top
`timescale 1ns/1ps

module xgmii_rx_top (
    input  logic                      clk,
    input  logic                      reset_crc,
    input  xgmii_rx_pkg::xgmii_data_t xgmii_rxd,
    input  xgmii_rx_pkg::xgmii_ctrl_t xgmii_rxc,
    input  logic                      cfg_rx_enable,
    output xgmii_rx_pkg::xgmii_data_t m_axis_tdata,
    output xgmii_rx_pkg::xgmii_ctrl_t m_axis_tkeep,
    output logic                      m_axis_tvalid,
    output logic                      m_axis_tlast,
    output logic                      m_axis_tuser,
    output logic                      stat_rx_pkt_good,
    output logic                      stat_rx_pkt_bad,
    output logic                      stat_rx_err_bad_fcs,
    output logic                      stat_rx_err_framing,
    output logic                      stat_rx_err_preamble,
    output xgmii_rx_pkg::pkt_len_t    stat_rx_pkt_len
);

    xgmii_rx_pkg::xgmii_data_t rxd_d0;
    xgmii_rx_pkg::xgmii_data_t rxd_d1;
    xgmii_rx_pkg::lane_idx_t   term_lane;
    xgmii_rx_pkg::lane_idx_t   term_lane_d0;
    logic                      start_d1;
    logic                      term_present;
    logic                      term_first_cycle;
    logic                      framing_error;
    logic                      framing_error_d0;
    logic                      crc_clear;
    logic [7:0]                crc_match;
    logic [7:0]                crc_match_save;

    xgmii_lane_decode u_decode (
        .clk              (clk),
        .reset_crc        (reset_crc),
        .xgmii_rxd        (xgmii_rxd),
        .xgmii_rxc        (xgmii_rxc),
        .rxd_d0           (rxd_d0),
        .rxd_d1           (rxd_d1),
        .start_d1         (start_d1),
        .term_present     (term_present),
        .term_first_cycle (term_first_cycle),
        .framing_error    (framing_error),
        .framing_error_d0 (framing_error_d0),
        .term_lane        (term_lane),
        .term_lane_d0     (term_lane_d0)
    );

    eth_crc32_64 u_crc (
        .clk            (clk),
        .reset_crc      (reset_crc),
        .crc_clear      (crc_clear),
        .rxd_d0         (rxd_d0),
        .crc_match      (crc_match),
        .crc_match_save (crc_match_save)
    );

    xgmii_rx_fsm u_fsm (
        .clk                  (clk),
        .reset_crc            (reset_crc),
        .cfg_rx_enable        (cfg_rx_enable),
        .start_d1             (start_d1),
        .term_present         (term_present),
        .term_first_cycle     (term_first_cycle),
        .framing_error        (framing_error),
        .framing_error_d0     (framing_error_d0),
        .rxd_d1               (rxd_d1),
        .term_lane            (term_lane),
        .term_lane_d0         (term_lane_d0),
        .crc_match            (crc_match),
        .crc_match_save       (crc_match_save),
        .crc_clear            (crc_clear),
        .m_axis_tdata         (m_axis_tdata),
        .m_axis_tkeep         (m_axis_tkeep),
        .m_axis_tvalid        (m_axis_tvalid),
        .m_axis_tlast         (m_axis_tlast),
        .m_axis_tuser         (m_axis_tuser),
        .stat_rx_pkt_good     (stat_rx_pkt_good),
        .stat_rx_pkt_bad      (stat_rx_pkt_bad),
        .stat_rx_err_bad_fcs  (stat_rx_err_bad_fcs),
        .stat_rx_err_framing  (stat_rx_err_framing),
        .stat_rx_err_preamble (stat_rx_err_preamble),
        .stat_rx_pkt_len      (stat_rx_pkt_len)
    );

endmodule

//--- xgmii_rx_sva.sv
// xgmii receiver assertions
`timescale 1ns/1ps

module xgmii_rx_sva (
    input logic clk,
    input logic reset_crc,
    input logic m_axis_tvalid,
    input logic m_axis_tlast,
    input logic stat_rx_pkt_good,
    input logic stat_rx_pkt_bad,
    input logic stat_rx_err_bad_fcs,
    input logic stat_rx_err_framing,
    input logic stat_rx_err_preamble
);

    logic stat_any;

    assign stat_any = stat_rx_pkt_good | stat_rx_pkt_bad | stat_rx_err_bad_fcs
                    | stat_rx_err_framing | stat_rx_err_preamble;

    // output registers clear one cycle into reset
    a_reset_quiet: assert property (@(posedge clk) reset_crc |=> !m_axis_tvalid)
        else $error("stream valid while in reset");

    a_stat_with_last: assert property (@(posedge clk) disable iff (reset_crc)
        stat_any |-> (m_axis_tvalid && m_axis_tlast))
        else $error("status pulse outside the last beat");

    a_good_bad_excl: assert property (@(posedge clk) disable iff (reset_crc)
        !(stat_rx_pkt_good && stat_rx_pkt_bad))
        else $error("good and bad status together");

endmodule

bind xgmii_rx_top xgmii_rx_sva u_sva (
    .clk                  (clk),
    .reset_crc            (reset_crc),
    .m_axis_tvalid        (m_axis_tvalid),
    .m_axis_tlast         (m_axis_tlast),
    .stat_rx_pkt_good     (stat_rx_pkt_good),
    .stat_rx_pkt_bad      (stat_rx_pkt_bad),
    .stat_rx_err_bad_fcs  (stat_rx_err_bad_fcs),
    .stat_rx_err_framing  (stat_rx_err_framing),
    .stat_rx_err_preamble (stat_rx_err_preamble)
);

//--- tb_xgmii_rx.sv
// xgmii receiver testbench
`timescale 1ns/1ps

module tb_xgmii_rx;

    localparam int clk_half = 5;
    localparam int reset_cycles = 16;
    localparam int frame_err_offset = 20;

    logic clk = 1'b0;
    logic reset_crc = 1'b1;
    logic [63:0] xgmii_rxd = {8{8'h07}};
    logic [7:0] xgmii_rxc = 8'hff;
    logic cfg_rx_enable = 1'b1;
    logic [63:0] m_axis_tdata;
    logic [7:0] m_axis_tkeep;
    logic m_axis_tvalid, m_axis_tlast, m_axis_tuser;
    logic stat_rx_pkt_good, stat_rx_pkt_bad, stat_rx_err_bad_fcs;
    logic stat_rx_err_framing, stat_rx_err_preamble;
    logic [15:0] stat_rx_pkt_len;

    logic [7:0] byte_q[$];
    bit ctrl_q[$];
    bit en_q[$];
    logic [63:0] word_d[$];
    logic [7:0] word_c[$];
    bit word_en[$];
    logic [7:0] exp_byte_q[$];
    int exp_len_q[$];
    // chk_len, tuser, good, bad, fcs, framing, preamble, length
    logic [22:0] exp_sum_q[$];
    logic [31:0] lfsr = 32'h1f2d7058;
    int errors = 0;
    int frames_checked = 0;
    int left = 0;
    bit build_done = 1'b0;
    bit file_ok = 1'b0;

    always #clk_half clk = ~clk;

    xgmii_rx_top u_dut (
        .clk (clk), .reset_crc (reset_crc), .xgmii_rxd (xgmii_rxd),
        .xgmii_rxc (xgmii_rxc), .cfg_rx_enable (cfg_rx_enable),
        .m_axis_tdata (m_axis_tdata), .m_axis_tkeep (m_axis_tkeep),
        .m_axis_tvalid (m_axis_tvalid), .m_axis_tlast (m_axis_tlast),
        .m_axis_tuser (m_axis_tuser), .stat_rx_pkt_good (stat_rx_pkt_good),
        .stat_rx_pkt_bad (stat_rx_pkt_bad), .stat_rx_err_bad_fcs (stat_rx_err_bad_fcs),
        .stat_rx_err_framing (stat_rx_err_framing),
        .stat_rx_err_preamble (stat_rx_err_preamble), .stat_rx_pkt_len (stat_rx_pkt_len)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // reflected ethernet crc over one byte
    function automatic logic [31:0] crc32_byte(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ b[i]) begin
                c = (c >> 1) ^ 32'hedb88320;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic push_byte(input logic [7:0] b, input bit c, input bit en);
        byte_q.push_back(b);
        ctrl_q.push_back(c);
        en_q.push_back(en);
    endtask

    task automatic build_frame(input int plen, input int kind, input bit en, input int gap);
        logic [31:0] crc;
        logic [31:0] fcs;
        logic [7:0] b;
        int kept;
        crc = 32'hffffffff;
        push_byte(8'hfb, 1'b1, en);
        for (int i = 1; i < 7; i++) begin
            push_byte((kind == 3 && i == 3) ? 8'h57 : 8'h55, 1'b0, en);
        end
        push_byte(8'hd5, 1'b0, en);
        kept = (kind == 2) ? (frame_err_offset / 8) * 8 : plen;
        for (int i = 0; i < plen; i++) begin
            for (int k = 0; k < 8; k++) begin
                lfsr = lfsr_next(lfsr);
                b[k] = lfsr[0];
            end
            crc = crc32_byte(crc, b);
            if (kind == 2 && i == frame_err_offset) begin
                push_byte(8'hfe, 1'b1, en);
            end else begin
                push_byte(b, 1'b0, en);
            end
            if (en && i < kept) begin
                exp_byte_q.push_back(b);
            end
        end
        fcs = ~crc;
        if (kind == 1) begin
            fcs[7:0] = ~fcs[7:0];
        end
        for (int i = 0; i < 4; i++) begin
            push_byte(fcs[i*8 +: 8], 1'b0, en);
        end
        push_byte(8'hfd, 1'b1, en);
        while (byte_q.size() % 8 != 0) begin
            push_byte(8'h07, 1'b1, en);
        end
        for (int i = 0; i < gap * 8; i++) begin
            push_byte(8'h07, 1'b1, en);
        end
        if (en) begin
            exp_len_q.push_back(kept);
            exp_sum_q.push_back({kind != 2, kind == 1 || kind == 2, kind == 0 || kind == 3,
                                 kind == 1 || kind == 2, kind == 1, kind == 2, kind == 3,
                                 16'(plen + 4)});
        end
    endtask

    task automatic read_frames(output bit opened);
        int fd;
        int plen, kind, en, gap;
        string line;
        fd = $fopen("xgmii_rx_input.txt", "r");
        opened = (fd != 0);
        if (opened) begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line.getc(0) != "#") begin
                    if ($sscanf(line, "%d %d %d %d", plen, kind, en, gap) == 4) begin
                        build_frame(plen, kind, en != 0, gap);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // pack bytes into words with lane 0 first
    task automatic pack_words();
        logic [63:0] d;
        logic [7:0] c;
        for (int w = 0; w < byte_q.size() / 8; w++) begin
            for (int n = 0; n < 8; n++) begin
                d[n*8 +: 8] = byte_q[w*8 + n];
                c[n] = ctrl_q[w*8 + n];
            end
            word_d.push_back(d);
            word_c.push_back(c);
            word_en.push_back(en_q[w*8]);
        end
    endtask

    initial begin
        for (int i = 0; i < 64; i++) begin
            push_byte(8'h07, 1'b1, 1'b1);
        end
        read_frames(file_ok);
        if (!file_ok) begin
            $display("cannot open the frame input file");
            $display("Test failures found");
            $finish;
        end else begin
            for (int i = 0; i < 192; i++) begin
                push_byte(8'h07, 1'b1, 1'b1);
            end
            pack_words();
            build_done = 1'b1;
            repeat (reset_cycles) @(posedge clk);
            #1;
            reset_crc = 1'b0;
            for (int w = 0; w < word_d.size(); w++) begin
                @(posedge clk);
                #1;
                xgmii_rxd = word_d[w];
                xgmii_rxc = word_c[w];
                cfg_rx_enable = word_en[w];
            end
            while (exp_sum_q.size() != 0) begin
                @(posedge clk);
            end
            repeat (8) @(posedge clk);
            if (exp_byte_q.size() != 0) begin
                errors++;
                $display("expected bytes were never delivered");
            end
            $display("checked %0d frames, %0d errors", frames_checked, errors);
            if (errors == 0) begin
                $display("All tests passed!");
            end else begin
                $display("Test failures found");
            end
            $finish;
        end
    end

    initial begin
        wait (build_done);
        #((word_d.size() + reset_cycles + 200) * 10);
        $display("timeout, the expected frames did not all arrive");
        $display("Test failures found");
        $finish;
    end

    // outputs are sampled on the falling edge
    always @(negedge clk) begin
        if (!reset_crc) begin
            if (m_axis_tvalid) begin
                if (left == 0 && exp_len_q.size() != 0) begin
                    left = exp_len_q.pop_front();
                end
                if (left == 0) begin
                    errors++;
                    $display("beat at %0t ns with no frame expected", $time);
                end else begin
                    check_value("tkeep", 64'(m_axis_tkeep),
                                (left >= 8) ? 64'hff : 64'((1 << left) - 1));
                    check_value("tlast", 64'(m_axis_tlast), 64'(left <= 8));
                    for (int n = 0; n < 8 && n < left; n++) begin
                        if (exp_byte_q.size() != 0) begin
                            check_value("tdata byte", 64'(m_axis_tdata[n*8 +: 8]),
                                        64'(exp_byte_q.pop_front()));
                        end
                    end
                    left = (left > 8) ? left - 8 : 0;
                end
                if (m_axis_tlast) begin
                    left = 0;
                    if (exp_sum_q.size() != 0) begin
                        check_frame_end(exp_sum_q.pop_front());
                    end
                end else begin
                    check_value("tuser before tlast", 64'(m_axis_tuser), 64'd0);
                    check_value("status without tlast", 64'({stat_rx_pkt_good,
                                stat_rx_pkt_bad, stat_rx_err_bad_fcs, stat_rx_err_framing,
                                stat_rx_err_preamble}), 64'd0);
                end
            end else if (stat_rx_pkt_good || stat_rx_pkt_bad || stat_rx_err_bad_fcs
                         || stat_rx_err_framing || stat_rx_err_preamble) begin
                errors++;
                $display("status pulse at %0t ns without a beat", $time);
            end
        end
    end

    task automatic check_frame_end(input logic [22:0] s);
        frames_checked++;
        check_value("tuser", 64'(m_axis_tuser), 64'(s[21]));
        check_value("status good,bad,fcs,framing,preamble",
                    64'({stat_rx_pkt_good, stat_rx_pkt_bad, stat_rx_err_bad_fcs,
                         stat_rx_err_framing, stat_rx_err_preamble}), 64'(s[20:16]));
        if (s[22]) begin
            check_value("pkt_len", 64'(stat_rx_pkt_len), 64'(s[15:0]));
        end
    endtask

endmodule

//--- xgmii_rx_input.txt
# columns: payload_length error_kind enable idle_words_after
# error_kind: 0 none, 1 bad fcs, 2 framing, 3 bad preamble
60 0 1 3
61 0 1 3
62 0 1 3
63 0 1 3
64 0 1 3
65 0 1 3
66 0 1 3
67 0 1 3
46 0 1 2
100 0 1 4
70 1 1 3
75 1 1 3
80 2 1 3
53 2 1 3
64 3 1 3
60 0 0 3
58 0 1 3
66 0 1 0
72 0 1 3
65 0 1 0
67 0 1 0
90 0 1 3
49 1 1 0
61 3 1 3

//--- sources.f
+incdir+.
xgmii_rx_pkg.sv
xgmii_lane_decode.sv
eth_crc32_64.sv
xgmii_rx_fsm.sv
xgmii_rx_top.sv
xgmii_rx_sva.sv
tb_xgmii_rx.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the xgmii receiver simulation with verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project directory"
    exit 1
fi

verilator --binary --timing -f sources.f --top-module tb_xgmii_rx -o sim_xgmii_rx
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_xgmii_rx > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
fi

if grep -q 'All tests passed!' sim.log; then
    exit 0
fi
exit 1
